// ==== files.f ====
logic/riu_bridge_pkg.sv
logic/io_bus_decode.sv
logic/riu_txn_tracker.sv
logic/riu_port.sv
logic/riu_bridge_top.sv
dv/riu_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RIU bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module riu_bridge_tb -f files.f -o riu_bridge_sim

status=0
./obj_dir/riu_bridge_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Run ended without a pass line, see sim.log"
  exit 1
fi
echo "Run passed"

// ==== dv/riu_bridge_tb.sv ====
`timescale 1ns/10ps

module riu_bridge_tb
  import riu_bridge_pkg::*;
();

  localparam int CH_NUM      = 4;
  localparam int CH_W        = $clog2(CH_NUM);
  localparam int TIMEOUT_CYC = 50;   // Bound on every wait
  localparam int STROBE_EDGE = 2;    // Edges after the bus strobe edge
  localparam int READY_EDGE  = 8;

  logic                   clk_riu = 1'b0;
  logic                   rst_riu;
  logic                   io_addr_strobe;
  logic                   io_read_strobe;
  logic                   io_write_strobe;
  bus_addr_t              io_address;
  bus_data_t              io_write_data;
  bus_data_t              io_read_data;
  logic                   io_ready;
  logic [CH_W-1:0]        ch_idx;
  riu_nibble_t            riu_nibble;
  riu_addr_t              riu_addr;
  riu_data_t              riu_wr_data;
  riu_data_t [CH_NUM-1:0] riu_rd_data;
  logic [CH_NUM-1:0]      riu_rd_strobe;
  logic [CH_NUM-1:0]      riu_wr_strobe;
  logic [CH_NUM-1:0]      riu_valid;
  logic                   ub_rst_out;

  riu_data_t phy_mem   [CH_NUM][16][256];  // PHY register file
  riu_data_t model_mem [CH_NUM][16][256];  // Reference mirror
  bit        fail_mode;                    // Next RIU write is refused by the PHY
  logic      exp_ub;                       // Expected soft reset level

  always #5 clk_riu = ~clk_riu;

  riu_bridge_top #(
    .CH_NUM (CH_NUM)
  ) dut_i (
    .clk_riu         (clk_riu),
    .rst_riu         (rst_riu),
    .io_addr_strobe  (io_addr_strobe),
    .io_read_strobe  (io_read_strobe),
    .io_write_strobe (io_write_strobe),
    .io_address      (io_address),
    .io_write_data   (io_write_data),
    .io_read_data    (io_read_data),
    .io_ready        (io_ready),
    .ch_idx          (ch_idx),
    .riu_nibble      (riu_nibble),
    .riu_addr        (riu_addr),
    .riu_wr_data     (riu_wr_data),
    .riu_rd_data     (riu_rd_data),
    .riu_rd_strobe   (riu_rd_strobe),
    .riu_wr_strobe   (riu_wr_strobe),
    .riu_valid       (riu_valid),
    .ub_rst_out      (ub_rst_out)
  );

  // Initial register contents, unique per channel, nibble and address
  function automatic riu_data_t fill_value(input int c, input int nib, input int a);
    return {2'b10, c[1:0], nib[3:0], a[7:0]};
  endfunction

  function automatic int rand_ch();
    return int'($urandom % CH_NUM);
  endfunction

  // Narrow mode folds accesses onto few registers so reads hit earlier writes
  function automatic bus_addr_t rand_riu_addr(input bit narrow);
    if (narrow) begin
      return {RIU_REGION, 8'($urandom), riu_nibble_t'($urandom % 4),
              riu_addr_t'($urandom % 8), 4'($urandom)};
    end
    return {RIU_REGION, 8'($urandom), riu_nibble_t'($urandom),
            riu_addr_t'($urandom), 4'($urandom)};
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string what, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      report_error($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_strobe(input string what, input logic [CH_NUM-1:0] got,
                              input logic [CH_NUM-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // PHY responder, samples strobes mid cycle and answers after the next edge
  initial begin
    logic [CH_NUM-1:0] rd_seen;
    logic [CH_NUM-1:0] wr_seen;
    riu_nibble_t       phy_nib;
    riu_addr_t         phy_addr;
    riu_data_t         phy_wdata;
    riu_valid   = '1;
    riu_rd_data = '0;
    for (int c = 0; c < CH_NUM; c++)
      for (int n = 0; n < 16; n++)
        for (int a = 0; a < 256; a++)
          phy_mem[c][n][a] = fill_value(c, n, a);
    forever begin
      @(negedge clk_riu);
      rd_seen   = riu_rd_strobe;
      wr_seen   = riu_wr_strobe;
      phy_nib   = riu_nibble;
      phy_addr  = riu_addr;
      phy_wdata = riu_wr_data;
      @(posedge clk_riu);
      #1;
      for (int c = 0; c < CH_NUM; c++) begin
        if (wr_seen[c] && fail_mode) riu_valid[c] = 1'b0;  // Refused write
        else if (wr_seen[c]) phy_mem[c][phy_nib][phy_addr] = phy_wdata;
        if (rd_seen[c]) riu_rd_data[c] = phy_mem[c][phy_nib][phy_addr];  // Held to next read
      end
      if (!fail_mode) riu_valid = '1;
    end
  end

  // One bus access, checked cycle by cycle against the expected timing
  task automatic do_access(input bit is_write, input bus_addr_t addr, input bus_data_t wdata,
                           input int ch);
    bit                riu_acc;
    bit                soft_acc;
    bit                failing;
    bit                seen;
    int                n;
    logic [CH_NUM-1:0] exp_strobe;
    riu_nibble_t       nib;
    riu_addr_t         ra;
    bus_data_t         exp_rd;
    riu_acc  = (addr[31:24] == RIU_REGION);
    soft_acc = is_write && (addr == SOFT_RST_ADDR);
    failing  = fail_mode && is_write && riu_acc;
    nib      = addr[15:12];
    ra       = addr[11:4];
    exp_rd   = {16'h0000, model_mem[ch][nib][ra]};  // Zero extended
    @(posedge clk_riu);
    #1;
    io_addr_strobe  = 1'b1;
    io_read_strobe  = !is_write;
    io_write_strobe = is_write;
    io_address      = addr;
    io_write_data   = wdata;
    ch_idx          = ch[CH_W-1:0];
    @(posedge clk_riu);  // Bus strobe edge
    #1;
    io_addr_strobe  = 1'b0;
    io_read_strobe  = 1'b0;
    io_write_strobe = 1'b0;
    seen = 1'b0;
    for (n = 1; n <= TIMEOUT_CYC && !seen; n++) begin
      @(negedge clk_riu);  // Value taken by edge n
      if (soft_acc && n == STROBE_EDGE) exp_ub = wdata[0];
      exp_strobe = '0;
      if (riu_acc && n == STROBE_EDGE) exp_strobe[ch] = 1'b1;
      check_strobe("riu_rd_strobe", riu_rd_strobe, is_write ? '0 : exp_strobe);
      check_strobe("riu_wr_strobe", riu_wr_strobe, is_write ? exp_strobe : '0);
      if (riu_acc && n == STROBE_EDGE) begin
        check_word("riu_nibble", bus_data_t'(riu_nibble), bus_data_t'(nib));
        check_word("riu_addr", bus_data_t'(riu_addr), bus_data_t'(ra));
        if (is_write) check_word("riu_wr_data", bus_data_t'(riu_wr_data), {16'h0000, wdata[15:0]});
      end
      check_bit("ub_rst_out", ub_rst_out, exp_ub);
      check_bit("io_ready", io_ready, riu_acc && !failing && n == READY_EDGE);
      if (io_ready) begin
        seen = 1'b1;
        if (!is_write) check_word("io_read_data", io_read_data, exp_rd);
      end
    end
    if (failing) begin
      fail_mode = 1'b0;  // PHY raises valid again
      for (n = 1; n <= TIMEOUT_CYC && !seen; n++) begin
        @(negedge clk_riu);
        seen = io_ready;
      end
    end
    if (riu_acc && !seen) begin
      report_error($sformatf("Timeout at %0t: no io_ready for the access to %h", $time, addr));
    end
    if (riu_acc && is_write && !failing) model_mem[ch][nib][ra] = wdata[15:0];
  endtask

  initial begin
    int        unused_seed;
    int        ch;
    bus_addr_t addr;
    bus_data_t wdata;
    unused_seed = $urandom(32'h77c6);  // Seeded once
    rst_riu         = 1'b1;
    io_addr_strobe  = 1'b0;
    io_read_strobe  = 1'b0;
    io_write_strobe = 1'b0;
    io_address      = '0;
    io_write_data   = '0;
    ch_idx          = '0;
    fail_mode       = 1'b0;
    exp_ub          = 1'b0;
    for (int c = 0; c < CH_NUM; c++)
      for (int n = 0; n < 16; n++)
        for (int a = 0; a < 256; a++)
          model_mem[c][n][a] = fill_value(c, n, a);
    for (int i = 0; i < 10; i++) @(posedge clk_riu);
    #1;
    rst_riu = 1'b0;

    // Idle state after reset
    @(negedge clk_riu);
    check_bit("io_ready", io_ready, 1'b0);
    check_strobe("riu_rd_strobe", riu_rd_strobe, '0);
    check_strobe("riu_wr_strobe", riu_wr_strobe, '0);
    check_bit("ub_rst_out", ub_rst_out, 1'b0);
    check_word("io_read_data", io_read_data, '0);

    for (int i = 0; i < 8; i++) do_access(1'b1, rand_riu_addr(1'b0), $urandom, rand_ch());

    for (int i = 0; i < 300; i++) do_access(1'($urandom), rand_riu_addr(1'b1), $urandom, rand_ch());

    // Refused writes, then read back the untouched register
    for (int i = 0; i < 2; i++) begin
      addr      = rand_riu_addr(1'b1);
      ch        = rand_ch();
      fail_mode = 1'b1;
      do_access(1'b1, addr, $urandom, ch);
      do_access(1'b0, addr, '0, ch);
    end

    for (int i = 0; i < 4; i++) begin
      wdata    = $urandom;
      wdata[0] = (i % 2 == 0);  // Set then clear
      do_access(1'b1, SOFT_RST_ADDR, wdata, rand_ch());
    end
    do_access(1'b1, {8'hCA, 24'($urandom)}, $urandom, rand_ch());  // Unmapped, no reply
    do_access(1'b0, {8'hCA, 24'($urandom)}, '0, rand_ch());
    do_access(1'b0, {8'h00, 24'($urandom)}, '0, rand_ch());

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== logic/riu_bridge_top.sv ====
`timescale 1ns/10ps

module riu_bridge_top
  import riu_bridge_pkg::*;
#(
  parameter int CH_NUM = 4
) (
  input  logic                      clk_riu,
  input  logic                      rst_riu,
  // Processor IO bus
  input  logic                      io_addr_strobe,
  input  logic                      io_read_strobe,
  input  logic                      io_write_strobe,
  input  bus_addr_t                 io_address,
  input  bus_data_t                 io_write_data,
  output bus_data_t                 io_read_data,
  output logic                      io_ready,
  input  logic [$clog2(CH_NUM)-1:0] ch_idx,
  // PHY register interface
  output riu_nibble_t               riu_nibble,
  output riu_addr_t                 riu_addr,
  output riu_data_t                 riu_wr_data,
  input  riu_data_t [CH_NUM-1:0]    riu_rd_data,
  output logic [CH_NUM-1:0]         riu_rd_strobe,
  output logic [CH_NUM-1:0]         riu_wr_strobe,
  input  logic [CH_NUM-1:0]         riu_valid,
  // Soft reset for the bank PLL
  output logic                      ub_rst_out
);

  logic      rd_launch;
  logic      wr_launch;
  bus_addr_t addr_q;
  bus_data_t wdata_q;
  riu_data_t rd_word;
  logic      sel_valid;
  logic      rd_done;
  logic      wr_done;

  io_bus_decode u_decode (
    .clk_riu         (clk_riu),
    .rst_riu         (rst_riu),
    .io_addr_strobe  (io_addr_strobe),
    .io_read_strobe  (io_read_strobe),
    .io_write_strobe (io_write_strobe),
    .io_address      (io_address),
    .io_write_data   (io_write_data),
    .io_read_data    (io_read_data),
    .io_ready        (io_ready),
    .ub_rst_out      (ub_rst_out),
    .rd_launch       (rd_launch),
    .wr_launch       (wr_launch),
    .addr_q          (addr_q),
    .wdata_q         (wdata_q),
    .rd_word         (rd_word),
    .rd_done         (rd_done),
    .wr_done         (wr_done)
  );

  riu_txn_tracker u_tracker (
    .clk_riu   (clk_riu),
    .rst_riu   (rst_riu),
    .rd_launch (rd_launch),
    .wr_launch (wr_launch),
    .sel_valid (sel_valid),
    .rd_done   (rd_done),
    .wr_done   (wr_done)
  );

  riu_port #(
    .CH_NUM (CH_NUM)
  ) u_port (
    .clk_riu       (clk_riu),
    .rst_riu       (rst_riu),
    .rd_launch     (rd_launch),
    .wr_launch     (wr_launch),
    .addr_q        (addr_q),
    .wdata_q       (wdata_q),
    .ch_idx        (ch_idx),
    .riu_rd_data   (riu_rd_data),
    .riu_valid     (riu_valid),
    .riu_rd_strobe (riu_rd_strobe),
    .riu_wr_strobe (riu_wr_strobe),
    .riu_nibble    (riu_nibble),
    .riu_addr      (riu_addr),
    .riu_wr_data   (riu_wr_data),
    .rd_word       (rd_word),
    .sel_valid     (sel_valid)
  );

endmodule

// ==== logic/riu_port.sv ====
`timescale 1ns/10ps

module riu_port
  import riu_bridge_pkg::*;
#(
  parameter int CH_NUM = 4           // PHY channels behind this bridge
) (
  input  logic                      clk_riu,
  input  logic                      rst_riu,
  // From the bus decode
  input  logic                      rd_launch,
  input  logic                      wr_launch,
  input  bus_addr_t                 addr_q,
  input  bus_data_t                 wdata_q,
  input  logic [$clog2(CH_NUM)-1:0] ch_idx,        // Channel of the current access
  // PHY side
  input  riu_data_t [CH_NUM-1:0]    riu_rd_data,
  input  logic [CH_NUM-1:0]         riu_valid,
  output logic [CH_NUM-1:0]         riu_rd_strobe,
  output logic [CH_NUM-1:0]         riu_wr_strobe,
  output riu_nibble_t               riu_nibble,
  output riu_addr_t                 riu_addr,
  output riu_data_t                 riu_wr_data,
  // Towards decode and tracker
  output riu_data_t                 rd_word,       // Selected data, two registers deep
  output logic                      sel_valid      // Selected valid, one register deep
);

  logic [CH_NUM-1:0]      rd_onehot;
  logic [CH_NUM-1:0]      wr_onehot;
  riu_data_t [CH_NUM-1:0] rd_data_q;               // All channels, before the mux
  logic [CH_NUM-1:0]      valid_q;

  // One hot strobe at the addressed channel
  always_comb begin
    rd_onehot         = '0;
    wr_onehot         = '0;
    rd_onehot[ch_idx] = rd_launch;
    wr_onehot[ch_idx] = wr_launch;
  end

  always_ff @(posedge clk_riu or posedge rst_riu) begin
    if (rst_riu) begin
      riu_rd_strobe <= '0;
      riu_wr_strobe <= '0;
    end else begin
      riu_rd_strobe <= rd_onehot;
      riu_wr_strobe <= wr_onehot;
    end
  end

  // RIU fields, aligned with the strobe
  always_ff @(posedge clk_riu) begin
    riu_nibble  <= addr_q[15:12];
    riu_addr    <= addr_q[11:4];
    riu_wr_data <= wdata_q[15:0];     // Upper half of the bus word is ignored
  end

  // Return path buffers
  always_ff @(posedge clk_riu) begin
    rd_data_q <= riu_rd_data;
    valid_q   <= riu_valid;
    rd_word   <= rd_data_q[ch_idx];   // Second stage after the channel mux
  end

  assign sel_valid = valid_q[ch_idx];

endmodule

// ==== logic/riu_txn_tracker.sv ====
`timescale 1ns/10ps

module riu_txn_tracker
  import riu_bridge_pkg::*;
(
  input  logic clk_riu,
  input  logic rst_riu,
  input  logic rd_launch,            // From the bus decode
  input  logic wr_launch,
  input  logic sel_valid,            // Selected channel valid, registered once
  output logic rd_done,
  output logic wr_done
);

  // Stage 0 of each line runs in step with the PHY strobe
  localparam int RD_DEPTH = RIU_RD_DELAY + 1;
  // One more stage on writes so the wait starts after valid has settled
  localparam int WR_DEPTH = RIU_WR_DELAY + 2;

  logic [RD_DEPTH-1:0] rd_pipe;      // Several reads may be in flight
  logic [WR_DEPTH-1:0] wr_pipe;
  logic                valid_wait;   // Write issued, waiting on channel valid

  // Launch delay lines
  always_ff @(posedge clk_riu or posedge rst_riu) begin
    if (rst_riu) begin
      rd_pipe <= '0;
      wr_pipe <= '0;
    end else begin
      rd_pipe <= {rd_pipe[RD_DEPTH-2:0], rd_launch};
      wr_pipe <= {wr_pipe[WR_DEPTH-2:0], wr_launch};
    end
  end

  // Reads always complete after the fixed delay
  assign rd_done = rd_pipe[RD_DEPTH-1];

  // Write wait flag
  always_ff @(posedge clk_riu or posedge rst_riu) begin
    if (rst_riu) begin
      valid_wait <= 1'b0;
    end else if (wr_pipe[WR_DEPTH-1]) begin
      valid_wait <= 1'b1;
    end else if (wr_done) begin
      valid_wait <= 1'b0;            // Cleared once the write is answered
    end
  end

  // A failed write holds valid low, so the flag just stays up
  assign wr_done = valid_wait & sel_valid;

endmodule

// ==== logic/io_bus_decode.sv ====
`timescale 1ns/10ps

module io_bus_decode
  import riu_bridge_pkg::*;
(
  input  logic      clk_riu,
  input  logic      rst_riu,
  // Processor IO bus
  input  logic      io_addr_strobe,
  input  logic      io_read_strobe,
  input  logic      io_write_strobe,
  input  bus_addr_t io_address,
  input  bus_data_t io_write_data,
  output bus_data_t io_read_data,
  output logic      io_ready,
  output logic      ub_rst_out,      // Soft reset level set by firmware
  // Towards the RIU port and the tracker
  output logic      rd_launch,       // RIU read accepted, one cycle
  output logic      wr_launch,       // RIU write accepted, one cycle
  output bus_addr_t addr_q,
  output bus_data_t wdata_q,
  // Completion side
  input  riu_data_t rd_word,         // Selected channel read data
  input  logic      rd_done,
  input  logic      wr_done
);

  logic      addr_strobe_q;          // Bus strobes, one cycle behind the bus
  logic      read_strobe_q;
  logic      write_strobe_q;
  logic      riu_hit;                // Registered address is in the RIU region
  logic      soft_rst_hit;           // Registered address is the soft reset register
  bus_data_t read_mux;

  // Bus strobes and address
  always_ff @(posedge clk_riu or posedge rst_riu) begin
    if (rst_riu) begin
      addr_strobe_q  <= 1'b0;
      read_strobe_q  <= 1'b0;
      write_strobe_q <= 1'b0;
      addr_q         <= '0;
    end else begin
      addr_strobe_q  <= io_addr_strobe;
      read_strobe_q  <= io_read_strobe;
      write_strobe_q <= io_write_strobe;
      addr_q         <= io_address;    // Held by the master until io_ready
    end
  end

  always_ff @(posedge clk_riu) begin
    wdata_q <= io_write_data;
  end

  // Region decode on the top address byte
  assign riu_hit      = (addr_q[31:24] == RIU_REGION);
  assign soft_rst_hit = (addr_q == SOFT_RST_ADDR);

  // Launch pulses, only for the RIU region
  // Any other address starts nothing and gets no reply
  assign rd_launch = addr_strobe_q & read_strobe_q & riu_hit;
  assign wr_launch = addr_strobe_q & write_strobe_q & riu_hit;

  // Firmware soft reset, bit 0 of the write word
  always_ff @(posedge clk_riu or posedge rst_riu) begin
    if (rst_riu) begin
      ub_rst_out <= 1'b0;
    end else if (addr_strobe_q && write_strobe_q && soft_rst_hit) begin
      ub_rst_out <= wdata_q[0];        // No io_ready for this write
    end
  end

  // Read word, zero extended RIU data or zero outside the region
  always_comb begin
    read_mux = '0;
    if (riu_hit) begin
      read_mux = {{($bits(bus_data_t) - $bits(riu_data_t)){1'b0}}, rd_word};
    end
  end

  // Response to the bus, data and ready on the same edge
  always_ff @(posedge clk_riu or posedge rst_riu) begin
    if (rst_riu) begin
      io_read_data <= '0;
      io_ready     <= 1'b0;
    end else begin
      io_read_data <= read_mux;
      io_ready     <= rd_done | wr_done;  // Single cycle pulse per access
    end
  end

endmodule

// ==== logic/riu_bridge_pkg.sv ====
package riu_bridge_pkg;

  // Processor IO bus
  typedef logic [31:0] bus_addr_t;             // Byte address from the soft processor
  typedef logic [31:0] bus_data_t;             // Read and write word

  // PHY register interface
  typedef logic [15:0] riu_data_t;             // RIU register data
  typedef logic [7:0]  riu_addr_t;             // Register address inside a nibble
  typedef logic [3:0]  riu_nibble_t;           // Nibble select within the bank

  // Address map, decoded on the registered bus address
  parameter logic [7:0] RIU_REGION    = 8'hDB;         // Top byte of every RIU access
  parameter bus_addr_t  SOFT_RST_ADDR = 32'hEF00_0000; // Firmware soft reset register

  // Read completes this many cycles after the strobe is tracked
  // Covers PHY input buffer, data out, PHY output buffer, input buffer and channel mux
  parameter int RIU_RD_DELAY = 5;

  // Cycles before the write waits on the channel valid
  // PHY drops valid within this window on a failed write
  parameter int RIU_WR_DELAY = 3;

endpackage
